/* rtl/hazardPkg.sv */
package hazardPkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    localparam int INSTR_W = 32;
    localparam int OP_W    = 6;
    localparam int FUNC_W  = 6;
    localparam int REG_W   = 5;
    localparam int DST_W   = 2;

    // Bit positions inside the instruction word
    localparam int OP_LSB   = 26;
    localparam int RS_LSB   = 21;
    localparam int RT_LSB   = 16;
    localparam int RD_LSB   = 11;
    localparam int FUNC_LSB = 0;

    typedef logic [INSTR_W-1:0] instrT;   // Raw IF/ID word
    typedef logic [OP_W-1:0]    opCodeT;  // Primary opcode
    typedef logic [FUNC_W-1:0]  funcT;    // R-type function field
    typedef logic [REG_W-1:0]   regIdxT;  // Register number
    typedef logic [DST_W-1:0]   regDstT;  // Destination select

    // ----------------------------------------
    // Primary opcodes
    // ----------------------------------------
    localparam opCodeT OP_RTYPE = 6'b000000;  // ALU ops, JR and JALR
    localparam opCodeT OP_J     = 6'b000010;
    localparam opCodeT OP_JAL   = 6'b000011;
    localparam opCodeT OP_BEQ   = 6'b000100;
    localparam opCodeT OP_BNE   = 6'b000101;
    localparam opCodeT OP_ADDI  = 6'b001000;
    localparam opCodeT OP_ADDIU = 6'b001001;
    localparam opCodeT OP_SLTI  = 6'b001010;
    localparam opCodeT OP_SLTIU = 6'b001011;
    localparam opCodeT OP_ANDI  = 6'b001100;
    localparam opCodeT OP_ORI   = 6'b001101;
    localparam opCodeT OP_XORI  = 6'b001110;
    localparam opCodeT OP_LUI   = 6'b001111;
    localparam opCodeT OP_LB    = 6'b100000;  // Loads start here
    localparam opCodeT OP_LH    = 6'b100001;
    localparam opCodeT OP_LW    = 6'b100011;
    localparam opCodeT OP_LBU   = 6'b100100;
    localparam opCodeT OP_LHU   = 6'b100101;
    localparam opCodeT OP_LWU   = 6'b100111;
    localparam opCodeT OP_SB    = 6'b101000;  // Stores
    localparam opCodeT OP_SH    = 6'b101001;
    localparam opCodeT OP_SW    = 6'b101011;
    localparam opCodeT OP_HALT  = 6'b111111;  // Debug stop

    // R-type function codes of interest
    localparam funcT FN_JR   = 6'b001000;
    localparam funcT FN_JALR = 6'b001001;

    // Destination select codes
    localparam regDstT DST_RT   = 2'd0;
    localparam regDstT DST_RD   = 2'd1;
    localparam regDstT DST_LINK = 2'd2;  // Link write to ra

    localparam regIdxT REG_RA = 5'd31;  // Return address register

endpackage

/* rtl/instrDecode.sv */
module instrDecode (
    input  hazardPkg::instrT  instrId,   // Word held in IF/ID
    output hazardPkg::opCodeT opCode,
    output hazardPkg::funcT   func,
    output hazardPkg::regIdxT regRs,
    output hazardPkg::regIdxT regRt,
    output hazardPkg::regIdxT regRd,
    output hazardPkg::regDstT regDst,    // Which field names the target
    output logic              regWrite,  // Instruction writes a register
    output logic              memRead    // Instruction is a load
);

    import hazardPkg::*;

    // ----------------------------------------
    // Field slicing
    // ----------------------------------------
    assign opCode = instrId[OP_LSB +: OP_W];
    assign regRs  = instrId[RS_LSB +: REG_W];
    assign regRt  = instrId[RT_LSB +: REG_W];
    assign regRd  = instrId[RD_LSB +: REG_W];
    assign func   = instrId[FUNC_LSB +: FUNC_W];  // Only meaningful for R-type

    // ----------------------------------------
    // Opcode classification
    // ----------------------------------------
    always_comb begin
        regDst   = DST_RT;  // Default target field
        regWrite = 1'b0;
        memRead  = 1'b0;

        case (opCode)
            OP_RTYPE: begin
                regDst   = DST_RD;
                regWrite = (func != FN_JR);  // JR has no result and JALR links to rd
            end

            OP_JAL: begin
                regDst   = DST_LINK;  // Writes ra
                regWrite = 1'b1;
            end

            // Loads target rt and read memory
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
            end

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                regWrite = 1'b1;  // Immediate result into rt
            end

            // No register result
            OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_J, OP_HALT: begin
                regWrite = 1'b0;
            end

            default: begin
                regWrite = 1'b0;  // Unknown opcode treated as a NOP
            end
        endcase
    end

endmodule

/* rtl/stageTracker.sv */
module stageTracker (
    input  logic              clk,
    input  logic              arstN,
    // Decoded ID instruction
    input  hazardPkg::regIdxT regRt,
    input  hazardPkg::regIdxT regRd,
    input  hazardPkg::regDstT regDst,
    input  logic              regWrite,
    input  logic              memRead,
    input  logic              controlStall,  // Bubble request from hazard unit
    // ID/EX shadow
    output hazardPkg::regIdxT idExRt,
    output hazardPkg::regIdxT idExRd,
    output hazardPkg::regDstT idExRegDst,
    output logic              idExRegWrite,
    output logic              idExMemRead,
    // EX/MEM shadow
    output hazardPkg::regIdxT exMemDst,
    output logic              exMemRegWrite,
    output logic              exMemMemRead,
    // MEM/WB shadow
    output hazardPkg::regIdxT memWbDst
);

    import hazardPkg::*;

    regIdxT idExDst;  // Resolved target of the ID/EX entry

    // ----------------------------------------
    // Destination resolution
    // ----------------------------------------
    always_comb begin
        case (idExRegDst)
            DST_RT:   idExDst = idExRt;
            DST_RD:   idExDst = idExRd;
            DST_LINK: idExDst = REG_RA;  // JAL writes ra
            default:  idExDst = idExRt;
        endcase
    end

    // ----------------------------------------
    // Pipeline shadow registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idExRt        <= '0;
            idExRd        <= '0;
            idExRegDst    <= DST_RT;
            idExRegWrite  <= 1'b0;
            idExMemRead   <= 1'b0;
            exMemDst      <= '0;
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            memWbDst      <= '0;
        end else begin
            // Register fields follow ID and the flags decide whether the entry counts
            idExRt     <= regRt;
            idExRd     <= regRd;
            idExRegDst <= regDst;
            if (controlStall) begin
                idExRegWrite <= 1'b0;  // Bubble
                idExMemRead  <= 1'b0;
            end else begin
                idExRegWrite <= regWrite;
                idExMemRead  <= memRead;
            end

            exMemDst      <= idExDst;  // One register number from here on
            exMemRegWrite <= idExRegWrite;
            exMemMemRead  <= idExMemRead;

            memWbDst <= exMemDst;
        end
    end

endmodule

/* rtl/hazardUnit.sv */
module hazardUnit (
    input  logic              arstN,
    // ID instruction
    input  hazardPkg::opCodeT opCode,
    input  hazardPkg::funcT   func,
    input  hazardPkg::regIdxT regRs,
    input  hazardPkg::regIdxT regRt,
    // Instruction in EX
    input  hazardPkg::regIdxT idExRt,
    input  hazardPkg::regIdxT idExRd,
    input  hazardPkg::regDstT idExRegDst,
    input  logic              idExRegWrite,
    input  logic              idExMemRead,
    // Instruction in MEM
    input  hazardPkg::regIdxT exMemDst,
    input  logic              exMemRegWrite,
    input  logic              exMemMemRead,
    // Instruction in WB
    input  hazardPkg::regIdxT memWbDst,
    output logic              pcWrite,
    output logic              ifIdWrite,
    output logic              controlStall,         // Bubble into ID/EX
    output logic              branchFlush,          // Kill the fetched word
    output logic              hazardCompareBranch,  // Early compare allowed in ID
    output logic              halt
);

    import hazardPkg::*;

    logic isBranch;
    logic isJr;
    logic isJalr;
    logic isJump;
    logic idExMatch;    // EX writer targets rs or rt
    logic exMemMatch;   // MEM target equals rs or rt
    logic memWbClear;   // WB target touches neither source
    logic linkPending;  // ra still being written ahead of JR
    logic rsPending;    // rs still being written ahead of JR or JALR

    // ----------------------------------------
    // Instruction class and operand matches
    // ----------------------------------------
    assign isBranch = (opCode == OP_BEQ) || (opCode == OP_BNE);
    assign isJr     = (opCode == OP_RTYPE) && (func == FN_JR);
    assign isJalr   = (opCode == OP_RTYPE) && (func == FN_JALR);
    assign isJump   = (opCode == OP_J) || (opCode == OP_JAL) || isJr || isJalr;

    // Select code picks which ID/EX field is compared
    assign idExMatch =
        ((idExRegDst == DST_RT) && ((idExRt == regRs) || (idExRt == regRt))) ||
        ((idExRegDst == DST_RD) && ((idExRd == regRs) || (idExRd == regRt)));

    assign exMemMatch = (exMemDst == regRs) || (exMemDst == regRt);
    assign memWbClear = (memWbDst != regRs) && (memWbDst != regRt);

    assign linkPending = (idExRegWrite && (idExRegDst == DST_LINK)) ||
                         (exMemRegWrite && (exMemDst == REG_RA));

    // Either EX field counts here without looking at the select
    assign rsPending = (idExRegWrite && ((idExRt == regRs) || (idExRd == regRs))) ||
                       (exMemRegWrite && (exMemDst == regRs));

    // ----------------------------------------
    // Priority chain
    // ----------------------------------------
    always_comb begin
        // Free-run pattern doubles as the reset pattern
        pcWrite             = 1'b1;
        ifIdWrite           = 1'b1;
        controlStall        = 1'b0;
        branchFlush         = 1'b0;
        hazardCompareBranch = 1'b0;

        if (arstN) begin
            if (isBranch && idExRegWrite && idExMatch) begin
                // Branch operand produced in EX
                pcWrite             = 1'b0;
                ifIdWrite           = 1'b0;
                controlStall        = 1'b1;
                hazardCompareBranch = memWbClear && !exMemMemRead;
            end else if (isBranch && exMemMemRead && exMemMatch) begin
                pcWrite      = 1'b0;  // Load data not back yet
                ifIdWrite    = 1'b0;
                controlStall = 1'b1;
            end else if (isBranch) begin
                hazardCompareBranch = !exMemMemRead;  // Operands ready
            end else if (idExMemRead && idExMatch) begin
                // Load-use
                pcWrite      = 1'b0;
                ifIdWrite    = 1'b0;
                controlStall = 1'b1;
            end else if (isJr && linkPending) begin
                pcWrite      = 1'b0;  // JAL still in flight
                ifIdWrite    = 1'b0;
                controlStall = 1'b1;
                branchFlush  = 1'b1;
            end else if ((isJr || isJalr) && rsPending) begin
                pcWrite      = 1'b0;
                ifIdWrite    = 1'b0;
                controlStall = 1'b1;
            end else if (isJump) begin
                ifIdWrite   = 1'b0;  // Redirect and drop the fetched word
                branchFlush = 1'b1;
            end
        end
    end

    assign halt = (opCode == OP_HALT);

endmodule

/* rtl/hazardTop.sv */
module hazardTop (
    input  logic             clk,
    input  logic             arstN,
    input  hazardPkg::instrT instrId,  // From the fetch side
    output logic             pcWrite,
    output logic             ifIdWrite,
    output logic             controlStall,
    output logic             branchFlush,
    output logic             hazardCompareBranch,
    output logic             halt
);

    import hazardPkg::*;

    // Decoded ID fields
    opCodeT opCode;
    funcT   func;
    regIdxT regRs;
    regIdxT regRt;
    regIdxT regRd;
    regDstT regDst;
    logic   regWrite;
    logic   memRead;

    // Tracker state
    regIdxT idExRt;
    regIdxT idExRd;
    regDstT idExRegDst;
    logic   idExRegWrite;
    logic   idExMemRead;
    regIdxT exMemDst;
    logic   exMemRegWrite;
    logic   exMemMemRead;
    regIdxT memWbDst;

    // ----------------------------------------
    // Decode, track, decide
    // ----------------------------------------
    instrDecode iDecode (
        .instrId  (instrId),
        .opCode   (opCode),
        .func     (func),
        .regRs    (regRs),
        .regRt    (regRt),
        .regRd    (regRd),
        .regDst   (regDst),
        .regWrite (regWrite),
        .memRead  (memRead)
    );

    stageTracker iTracker (
        .clk           (clk),
        .arstN         (arstN),
        .regRt         (regRt),
        .regRd         (regRd),
        .regDst        (regDst),
        .regWrite      (regWrite),
        .memRead       (memRead),
        .controlStall  (controlStall),  // Stall feeds back as a bubble
        .idExRt        (idExRt),
        .idExRd        (idExRd),
        .idExRegDst    (idExRegDst),
        .idExRegWrite  (idExRegWrite),
        .idExMemRead   (idExMemRead),
        .exMemDst      (exMemDst),
        .exMemRegWrite (exMemRegWrite),
        .exMemMemRead  (exMemMemRead),
        .memWbDst      (memWbDst)
    );

    hazardUnit iHazard (
        .arstN               (arstN),
        .opCode              (opCode),
        .func                (func),
        .regRs               (regRs),
        .regRt               (regRt),
        .idExRt              (idExRt),
        .idExRd              (idExRd),
        .idExRegDst          (idExRegDst),
        .idExRegWrite        (idExRegWrite),
        .idExMemRead         (idExMemRead),
        .exMemDst            (exMemDst),
        .exMemRegWrite       (exMemRegWrite),
        .exMemMemRead        (exMemMemRead),
        .memWbDst            (memWbDst),
        .pcWrite             (pcWrite),
        .ifIdWrite           (ifIdWrite),
        .controlStall        (controlStall),
        .branchFlush         (branchFlush),
        .hazardCompareBranch (hazardCompareBranch),
        .halt                (halt)
    );

endmodule

/* tests/hazardChecker.sv */
module hazardChecker (
    input  logic             clk,
    input  logic             arstN,
    input  hazardPkg::instrT instrId,  // Same word the DUT decodes
    input  logic             pcWrite,
    input  logic             ifIdWrite,
    input  logic             controlStall,
    input  logic             branchFlush,
    input  logic             hazardCompareBranch,
    input  logic             halt,
    output int               errorCount
);

    import hazardPkg::*;

    // {pcWrite, ifIdWrite, controlStall, branchFlush, hazardCompareBranch}
    localparam logic [4:0] FREE        = 5'b11000;
    localparam logic [4:0] STALL       = 5'b00100;
    localparam logic [4:0] STALL_FLUSH = 5'b00110;  // JR waiting on ra
    localparam logic [4:0] JUMP        = 5'b10010;

    opCodeT     idOp;
    funcT       idFunc;
    regIdxT     idRs;
    regIdxT     idRt;
    logic       idWrite;
    logic       idLoad;
    regDstT     idSel;
    regIdxT     exRt;     // Model of ID/EX
    regIdxT     exRd;
    regDstT     exSel;
    logic       exWrite;
    logic       exLoad;
    regIdxT     memDst;   // Model of EX/MEM
    logic       memWrite;
    logic       memLoad;
    regIdxT     wbDst;    // Model of MEM/WB
    regIdxT     exDst;
    logic       exHit;
    logic       memHit;
    logic       wbClear;
    logic       isBranch;
    logic       isJr;
    logic       isJalr;
    logic [4:0] expCtl;

    // MIPS field layout
    assign idOp   = instrId[31:26];
    assign idRs   = instrId[25:21];
    assign idRt   = instrId[20:16];
    assign idFunc = instrId[5:0];

    // ----------------------------------------
    // Reference decode
    // ----------------------------------------
    always_comb begin
        idWrite = 1'b0;
        idLoad  = 1'b0;
        idSel   = DST_RT;
        case (idOp)
            OP_RTYPE: begin
                idSel   = DST_RD;
                idWrite = (idFunc != FN_JR);  // JALR still writes rd
            end
            OP_JAL: begin
                idSel   = DST_LINK;
                idWrite = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
                idWrite = 1'b1;
                idLoad  = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                idWrite = 1'b1;
            end
            default: idWrite = 1'b0;  // Stores, branches, J, HALT
        endcase
    end

    // ----------------------------------------
    // Hazard rules, first match wins
    // ----------------------------------------
    always_comb begin
        exDst    = (exSel == DST_RD) ? exRd : exRt;
        exHit    = (exSel != DST_LINK) && ((exDst == idRs) || (exDst == idRt));
        memHit   = (memDst == idRs) || (memDst == idRt);
        wbClear  = (wbDst != idRs) && (wbDst != idRt);
        isBranch = (idOp == OP_BEQ) || (idOp == OP_BNE);
        isJr     = (idOp == OP_RTYPE) && (idFunc == FN_JR);
        isJalr   = (idOp == OP_RTYPE) && (idFunc == FN_JALR);
        if (!arstN) begin
            expCtl = FREE;
        end else if (isBranch && exWrite && exHit) begin
            expCtl = STALL | {4'b0000, wbClear && !memLoad};
        end else if (isBranch && memLoad && memHit) begin
            expCtl = STALL;
        end else if (isBranch) begin
            expCtl = FREE | {4'b0000, !memLoad};  // Early compare unless a load sits in MEM
        end else if (exLoad && exHit) begin
            expCtl = STALL;  // Load-use
        end else if (isJr &&
                     ((exWrite && exSel == DST_LINK) || (memWrite && memDst == REG_RA))) begin
            expCtl = STALL_FLUSH;
        end else if ((isJr || isJalr) &&
                     ((exWrite && (exRt == idRs || exRd == idRs)) ||
                      (memWrite && memDst == idRs))) begin
            expCtl = STALL;
        end else if (idOp == OP_J || idOp == OP_JAL || isJr || isJalr) begin
            expCtl = JUMP;
        end else begin
            expCtl = FREE;
        end
    end

    // Shadow pipeline with a bubble whenever the model stalls
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exRt     <= '0;
            exRd     <= '0;
            exSel    <= DST_RT;
            exWrite  <= 1'b0;
            exLoad   <= 1'b0;
            memDst   <= '0;
            memWrite <= 1'b0;
            memLoad  <= 1'b0;
            wbDst    <= '0;
        end else begin
            exRt     <= idRt;
            exRd     <= instrId[15:11];
            exSel    <= idSel;
            exWrite  <= idWrite && !expCtl[2];
            exLoad   <= idLoad && !expCtl[2];
            memDst   <= (exSel == DST_LINK) ? REG_RA : exDst;
            memWrite <= exWrite;
            memLoad  <= exLoad;
            wbDst    <= memDst;
        end
    end

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Outputs settled since the last rising edge
    always @(negedge clk) begin
        compareBit("pcWrite", expCtl[4], pcWrite);
        compareBit("ifIdWrite", expCtl[3], ifIdWrite);
        compareBit("controlStall", expCtl[2], controlStall);
        compareBit("branchFlush", expCtl[1], branchFlush);
        compareBit("hazardCompareBranch", expCtl[0], hazardCompareBranch);
        compareBit("halt", idOp == OP_HALT, halt);  // Independent of stalls
    end

endmodule

/* tests/tbHazardTop.sv */
module tbHazardTop;

    import hazardPkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_CYCLES   = 2000;  // Stimulus length after reset
    localparam int MARGIN       = 20;

    // Opcode pools indexed by LFSR bits
    localparam opCodeT LOAD_OPS [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU,
                                        OP_LHU, OP_LWU, OP_LW, OP_LB};
    localparam opCodeT STORE_OPS [4] = '{OP_SB, OP_SH, OP_SW, OP_SW};
    localparam opCodeT IMM_OPS [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                       OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    logic        clk = 1'b0;
    logic        arstN;
    instrT       instrId = '0;
    logic        pcWrite;
    logic        ifIdWrite;
    logic        controlStall;
    logic        branchFlush;
    logic        hazardCompareBranch;
    logic        halt;
    int          errorCount;
    int          cycleCount = 0;
    int          resetEdges = 0;
    logic [31:0] lfsrState = 32'h6b74;

    always #(CLK_PERIOD / 2) clk = ~clk;

    hazardTop i_dut (
        .clk                 (clk),
        .arstN               (arstN),
        .instrId             (instrId),
        .pcWrite             (pcWrite),
        .ifIdWrite           (ifIdWrite),
        .controlStall        (controlStall),
        .branchFlush         (branchFlush),
        .hazardCompareBranch (hazardCompareBranch),
        .halt                (halt)
    );

    hazardChecker iChecker (
        .clk                 (clk),
        .arstN               (arstN),
        .instrId             (instrId),
        .pcWrite             (pcWrite),
        .ifIdWrite           (ifIdWrite),
        .controlStall        (controlStall),
        .branchFlush         (branchFlush),
        .hazardCompareBranch (hazardCompareBranch),
        .halt                (halt),
        .errorCount          (errorCount)
    );

    // ----------------------------------------
    // Random source
    // ----------------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        // x^32+x^22+x^2+x+1
        lfsrStep = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
    endtask

    // Registers 0 to 3 or ra make dependencies common
    task automatic pickReg(output regIdxT idx);
        logic [31:0] bits;
        takeBits(3, bits);
        idx = (bits[2] && bits[0]) ? REG_RA : {3'b000, bits[1:0]};
    endtask

    task automatic makeInstr(output instrT word);
        logic [31:0] bits;
        opCodeT      op;
        funcT        fn;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        takeBits(4, bits);
        op = OP_RTYPE;
        fn = 6'h20;  // ADD function or low immediate bits for I-type
        case (bits[3:0])
            4'd1, 4'd11: begin
                takeBits(3, bits);
                op = LOAD_OPS[bits[2:0]];
            end
            4'd2, 4'd12: begin
                takeBits(2, bits);
                op = STORE_OPS[bits[1:0]];
            end
            4'd3, 4'd13: begin
                takeBits(3, bits);
                op = IMM_OPS[bits[2:0]];
            end
            4'd4, 4'd15: begin
                takeBits(1, bits);
                op = bits[0] ? OP_BNE : OP_BEQ;
            end
            4'd5: op = OP_J;
            4'd6: op = OP_JAL;
            4'd7: fn = FN_JR;
            4'd8: fn = FN_JALR;
            4'd9: op = OP_HALT;
            default: op = OP_RTYPE;  // Plain ALU op
        endcase
        pickReg(rs);
        pickReg(rt);
        pickReg(rd);
        word = {op, rs, rt, rd, 5'd0, fn};
    endtask

    // ----------------------------------------
    // Fetch stage model
    // ----------------------------------------
    always @(posedge clk) begin
        instrT nextWord;
        if (!arstN) begin
            // A jump sits in IF/ID through reset and a NOP follows on the last edge
            resetEdges <= resetEdges + 1;
            instrId    <= (resetEdges < RESET_CYCLES - 1) ? {OP_J, 26'd0} : '0;
        end else if (cycleCount < NUM_CYCLES) begin
            cycleCount <= cycleCount + 1;
            if (!pcWrite) begin
                instrId <= instrId;  // Hold IF/ID
            end else if (branchFlush) begin
                instrId <= '0;       // Fetched word killed
            end else begin
                makeInstr(nextWord);
                instrId <= nextWord;
            end
        end
    end

    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        wait (cycleCount == NUM_CYCLES);
        repeat (2) @(posedge clk);  // Let the last compares land
        $display("Error count: %0d", errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_CYCLES + MARGIN));
        $display("Timeout: stimulus did not complete in the expected number of cycles");
        $display("Errors found");
        $finish;
    end

endmodule

/* sim.f */
rtl/hazardPkg.sv
rtl/instrDecode.sv
rtl/stageTracker.sv
rtl/hazardUnit.sv
rtl/hazardTop.sv
tests/hazardChecker.sv
tests/tbHazardTop.sv

/* runSim.sh */
#!/bin/bash
# Build and run the hazard unit testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing -f sim.f --top-module tbHazardTop -o simv \
    && simOut="$(./obj_dir/simv)" \
    && echo "$simOut" \
    && grep -qx "No errors" <<< "$simOut" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
